/* verilog.f */
+incdir+design
design/i2s_rx_pkg.sv
design/i2s_rx_sync.sv
design/i2s_rx_deser.sv
design/i2s_rx_bist_mux.sv
design/i2s_rx_fifo.sv
design/i2s_rx_regs.sv
design/i2s_rx_top.sv
dv/i2s_rx_chk.sv
dv/i2s_rx_tb.sv

/* run.sh */
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal --top-module i2s_rx_tb -f verilog.f -o i2s_rx_sim
./obj_dir/i2s_rx_sim +verilator+error+limit+1000 | tee sim.log

if grep -q "Errors found" sim.log; then
    echo "Simulation FAILED"
    exit 1
fi
if ! grep -q "No errors" sim.log; then
    echo "Simulation ended without a result"
    exit 1
fi
echo "Simulation PASSED"

/* dv/i2s_rx_tb.sv */
`timescale 1ns/1ps
`include "i2s_rx_cfg.svh"

module i2s_rx_tb;

    import i2s_rx_pkg::*;

    localparam int unsigned HALF_CLKS  = 4;              // clk cycles per sck half period
    localparam int unsigned SLOTS      = 32;             // sck periods per channel word
    localparam int unsigned FRAME_CLKS = 2 * SLOTS * 2 * HALF_CLKS;
    localparam int unsigned N_FRAMES   = 4 + 12 + 12 + 8;  // en low, random, overrun, ramp
    localparam int unsigned WATCHDOG   = N_FRAMES * FRAME_CLKS + 2000;
    localparam int unsigned DRAIN_CLKS = 1000;

    logic        clk;
    logic        rst_n;
    logic        sck_pin;
    logic        ws_pin;
    logic        sd_pin;
    apb_req_t    apb_req;
    apb_rsp_t    apb_rsp;
    frame_t      out_frame;
    logic        out_valid;
    logic        out_ready;
    logic        ready_rand;                             // out_ready follows the LFSR
    logic        ready_hold;
    logic [31:0] lfsr_q;
    logic [31:0] tx_buf [12];
    logic [31:0] exp_q [$];                              // Expected frames with left in the upper half
    logic [31:0] mon_exp;
    int unsigned err_cnt;

    i2s_rx_top dut (
        .clk       (clk),
        .rst_n     (rst_n),
        .sck_pin   (sck_pin),
        .ws_pin    (ws_pin),
        .sd_pin    (sd_pin),
        .apb_req   (apb_req),
        .apb_rsp   (apb_rsp),
        .out_frame (out_frame),
        .out_valid (out_valid),
        .out_ready (out_ready)
    );

    always #50 clk = ~clk;

    // x^32 + x^22 + x^2 + x + 1
    function automatic logic rand_bit();
        lfsr_q = {lfsr_q[30:0], lfsr_q[31] ^ lfsr_q[21] ^ lfsr_q[1] ^ lfsr_q[0]};
        return lfsr_q[0];
    endfunction

    always @(posedge clk)
    begin
        if (ready_rand)
            out_ready <= rand_bit();
        else
            out_ready <= ready_hold;
    end

    // Compare every transfer with the head of the reference queue
    always @(posedge clk)
    begin
        if (rst_n && out_valid && out_ready)
        begin
            assert (exp_q.size() != 0)
            else
            begin
                err_cnt++;
                $display("Frame 0x%08h came out while no frame was expected", out_frame);
            end
            if (exp_q.size() != 0)
            begin
                mon_exp = exp_q.pop_front();
                assert (out_frame == mon_exp)
                else
                begin
                    err_cnt++;
                    $display("[FAIL] out_frame exp 0x%08h got 0x%08h", mon_exp, out_frame);
                end
            end
        end
    end

    initial
    begin
        repeat (WATCHDOG) @(posedge clk);
        $display("Watchdog expired after %0d clk cycles, the run did not finish", WATCHDOG);
        $display("Errors found");
        $finish;
    end

    ////////////////////////////////////////////////////////////////////////////
    // APB access
    ////////////////////////////////////////////////////////////////////////////

    task automatic apb_access(input logic wr, input logic [7:0] addr, input logic [31:0] wdata,
                              output logic [31:0] rdata, output logic err);
        int unsigned waits;
        waits = 0;
        apb_req <= '{paddr: addr, psel: 1'b1, penable: 1'b0, pwrite: wr, pwdata: wdata};
        @(posedge clk);
        apb_req.penable <= 1'b1;
        @(posedge clk);
        while (!apb_rsp.pready && waits < 16)
        begin
            waits++;
            @(posedge clk);
        end
        assert (apb_rsp.pready)
        else
        begin
            err_cnt++;
            $display("APB access to 0x%02h never completed", addr);
        end
        rdata = apb_rsp.prdata;
        err   = apb_rsp.pslverr;
        apb_req <= '0;
    endtask

    task automatic write_reg(input logic [7:0] addr, input logic [31:0] data);
        logic [31:0] rd;
        logic        err;
        apb_access(1'b1, addr, data, rd, err);
        assert (!err)
        else
        begin
            err_cnt++;
            $display("[FAIL] pslverr on write 0x%02h exp 0x0 got 0x1", addr);
        end
    endtask

    task automatic check_reg(input logic [7:0] addr, input logic [31:0] exp, input logic exp_err);
        logic [31:0] rd;
        logic        err;
        apb_access(1'b0, addr, '0, rd, err);
        assert (rd == exp)
        else
        begin
            err_cnt++;
            $display("[FAIL] prdata at 0x%02h exp 0x%08h got 0x%08h", addr, exp, rd);
        end
        assert (err == exp_err)
        else
        begin
            err_cnt++;
            $display("[FAIL] pslverr at 0x%02h exp 0x%0h got 0x%0h", addr, exp_err, err);
        end
    endtask

    ////////////////////////////////////////////////////////////////////////////
    // I2S serial driver
    ////////////////////////////////////////////////////////////////////////////

    // ws and sd change with the falling sck edge
    task automatic sck_cycle(input logic w, input logic d);
        sck_pin <= 1'b0;
        ws_pin  <= w;
        sd_pin  <= d;
        repeat (HALF_CLKS) @(posedge clk);
        sck_pin <= 1'b1;
        repeat (HALF_CLKS) @(posedge clk);
    endtask

    task automatic send_word(input logic w, input logic [15:0] smp);
        for (int s = 0; s < SLOTS; s++)
            sck_cycle(w, (s >= 1 && s <= 16) ? smp[16 - s] : 1'b1);   // Pad bits set
    endtask

    task automatic gen_frames(input int n);
        for (int i = 0; i < n; i++)
            for (int b = 0; b < 32; b++)
                tx_buf[i] = {tx_buf[i][30:0], rand_bit()};
    endtask

    // ws high lead-in makes the first left word start on a ws fall
    task automatic send_frames(input int n);
        sck_cycle(1'b1, 1'b0);
        sck_cycle(1'b1, 1'b0);
        for (int i = 0; i < n; i++)
        begin
            send_word(1'b0, tx_buf[i][31:16]);
            send_word(1'b1, tx_buf[i][15:0]);
        end
        sck_cycle(1'b0, 1'b0);                           // ws fall closes the last pair
        sck_cycle(1'b0, 1'b0);
    endtask

    task automatic wait_drain();
        int unsigned n;
        n = 0;
        while (exp_q.size() != 0 && n < DRAIN_CLKS)
        begin
            n++;
            @(posedge clk);
        end
        assert (exp_q.size() == 0)
        else
        begin
            err_cnt++;
            $display("%0d expected frames never came out", exp_q.size());
        end
        exp_q.delete();
    endtask

    task automatic run_ramp();
        logic [11:0] ramp;
        logic [12:0] sum;
        int unsigned n;
        ramp = 12'h0F0;
        for (int i = 0; i < 8; i++)
        begin
            exp_q.push_back({4'h0, ramp, 4'h0, ramp});
            sum  = {1'b0, ramp} + 13'h040;
            ramp = (sum > 13'h1A0) ? 12'h0F0 : sum[11:0];  // Wrap to the start past the limit
        end
        write_reg(`I2S_RX_ADDR_BIST_START, 32'h0F0);
        write_reg(`I2S_RX_ADDR_BIST_INC, 32'h40);
        write_reg(`I2S_RX_ADDR_BIST_LIMIT, 32'h1A0);
        write_reg(`I2S_RX_ADDR_CTRL, 32'h2);
        n = 0;
        while (exp_q.size() != 0 && n < 8 * `I2S_RX_BIST_DIV + 8)
        begin
            n++;
            sck_cycle(1'b1, 1'b0);
        end
        wait_drain();
        write_reg(`I2S_RX_ADDR_CTRL, 32'h0);
    endtask

    ////////////////////////////////////////////////////////////////////////////
    // Test sequence
    ////////////////////////////////////////////////////////////////////////////

    initial
    begin
        int unsigned chk_fails;
        clk        = 1'b0;
        rst_n      = 1'b0;
        sck_pin    = 1'b0;
        ws_pin     = 1'b1;
        sd_pin     = 1'b0;
        apb_req    = '0;
        out_ready  = 1'b0;
        ready_rand = 1'b0;
        ready_hold = 1'b0;
        lfsr_q     = 32'h11be;
        err_cnt    = 0;
        repeat (8) @(posedge clk);
        rst_n <= 1'b1;
        @(posedge clk);

        // Register fields read back masked to their widths
        write_reg(`I2S_RX_ADDR_CTRL, 32'hFFFF_FFFF);
        write_reg(`I2S_RX_ADDR_BIST_START, 32'hFFFF_FFFF);
        write_reg(`I2S_RX_ADDR_BIST_INC, 32'hFFFF_FFFF);
        write_reg(`I2S_RX_ADDR_BIST_LIMIT, 32'hFFFF_FFFF);
        check_reg(`I2S_RX_ADDR_CTRL, 32'h3, 1'b0);
        check_reg(`I2S_RX_ADDR_BIST_START, 32'hFFF, 1'b0);
        check_reg(`I2S_RX_ADDR_BIST_INC, 32'hFF, 1'b0);
        check_reg(`I2S_RX_ADDR_BIST_LIMIT, 32'hFFF, 1'b0);
        check_reg(8'h20, 32'h0, 1'b1);
        write_reg(`I2S_RX_ADDR_CTRL, 32'h0);

        // Disabled receiver
        ready_hold <= 1'b1;
        gen_frames(4);
        send_frames(4);
        repeat (16) @(posedge clk);
        check_reg(`I2S_RX_ADDR_STATUS, 32'h0, 1'b0);

        // Random frames with a random consumer
        write_reg(`I2S_RX_ADDR_CTRL, 32'h1);
        gen_frames(12);
        for (int i = 0; i < 12; i++)
            exp_q.push_back(tx_buf[i]);
        ready_rand <= 1'b1;
        send_frames(12);
        wait_drain();
        ready_rand <= 1'b0;
        @(posedge clk);                                  // Consumer stops drawing LFSR bits

        // Overrun with the consumer stalled
        ready_hold <= 1'b0;
        gen_frames(12);
        for (int i = 0; i < `I2S_RX_FIFO_DEPTH; i++)
            exp_q.push_back(tx_buf[i]);
        send_frames(12);
        repeat (4) @(posedge clk);
        check_reg(`I2S_RX_ADDR_STATUS, 32'h1, 1'b0);
        ready_hold <= 1'b1;
        wait_drain();
        repeat (4) @(posedge clk);
        assert (!out_valid)
        else
        begin
            err_cnt++;
            $display("[FAIL] out_valid exp 0x0 got 0x1");
        end
        write_reg(`I2S_RX_ADDR_STATUS, 32'h1);
        check_reg(`I2S_RX_ADDR_STATUS, 32'h0, 1'b0);
        write_reg(`I2S_RX_ADDR_CTRL, 32'h0);

        run_ramp();

        repeat (8) @(posedge clk);
        chk_fails = dut.u_chk.fail_cnt;
        $display("Check errors: %0d, assertion errors: %0d", err_cnt, chk_fails);
        if (err_cnt == 0 && chk_fails == 0)
            $display("No errors");
        else
            $display("Errors found");
        $finish;
    end

endmodule

/* dv/i2s_rx_chk.sv */
`timescale 1ns/1ps

module i2s_rx_chk (
    input  logic                 clk,
    input  logic                 rst_n,
    input  i2s_rx_pkg::apb_req_t apb_req,
    input  i2s_rx_pkg::apb_rsp_t apb_rsp,
    input  i2s_rx_pkg::frame_t   out_frame,
    input  logic                 out_valid,
    input  logic                 out_ready
);

    import i2s_rx_pkg::*;

    int unsigned fail_cnt = 0;                  // Failed assertions so far

    // A stalled head frame has to wait unchanged for the consumer
    stall_stable: assert property (@(posedge clk) disable iff (!rst_n)
        out_valid && !out_ready |=> $stable(out_frame))
    else
    begin
        fail_cnt++;
        $error("out_frame changed while out_valid was high and out_ready low");
    end

    apb_ready: assert property (@(posedge clk) disable iff (!rst_n)
        apb_req.psel && apb_req.penable |-> apb_rsp.pready)
    else
    begin
        fail_cnt++;
        $error("pready was low in an APB access phase");
    end

    reset_idle: assert property (@(posedge clk) !rst_n |-> !out_valid)
    else
    begin
        fail_cnt++;
        $error("out_valid was high during reset");
    end

endmodule

bind i2s_rx_top i2s_rx_chk u_chk (
    .clk       (clk),
    .rst_n     (rst_n),
    .apb_req   (apb_req),
    .apb_rsp   (apb_rsp),
    .out_frame (out_frame),
    .out_valid (out_valid),
    .out_ready (out_ready)
);

/* design/i2s_rx_top.sv */
`timescale 1ns/1ps

module i2s_rx_top (
    input  logic                 clk,
    input  logic                 rst_n,
    input  logic                 sck_pin,
    input  logic                 ws_pin,
    input  logic                 sd_pin,
    input  i2s_rx_pkg::apb_req_t apb_req,
    output i2s_rx_pkg::apb_rsp_t apb_rsp,
    output i2s_rx_pkg::frame_t   out_frame,
    output logic                 out_valid,
    input  logic                 out_ready
);

    import i2s_rx_pkg::*;

    logic    sck_rise;
    logic    ws_s;                              // Synchronized word select
    logic    sd_s;                              // Synchronized serial data
    rx_cfg_t cfg;
    frame_t  deser_frame;
    logic    deser_push;
    frame_t  src_frame;                         // Selected frame source
    logic    src_push;
    logic    drop;

    ////////////////////////////////////////////////////////////////////////////
    // Input side
    ////////////////////////////////////////////////////////////////////////////

    i2s_rx_sync u_sync (
        .clk        (clk),
        .rst_n      (rst_n),
        .sck_pin    (sck_pin),
        .ws_pin     (ws_pin),
        .sd_pin     (sd_pin),
        .sck_rise   (sck_rise),
        .ws         (ws_s),
        .sd         (sd_s)
    );

    i2s_rx_deser u_deser (
        .clk        (clk),
        .rst_n      (rst_n),
        .sck_rise   (sck_rise),
        .ws         (ws_s),
        .sd         (sd_s),
        .cfg        (cfg),
        .frame      (deser_frame),
        .frame_push (deser_push)
    );

    i2s_rx_bist_mux u_bist_mux (
        .clk         (clk),
        .rst_n       (rst_n),
        .sck_rise    (sck_rise),
        .cfg         (cfg),
        .deser_frame (deser_frame),
        .deser_push  (deser_push),
        .frame       (src_frame),
        .push        (src_push)
    );

    ////////////////////////////////////////////////////////////////////////////
    // Output side
    ////////////////////////////////////////////////////////////////////////////

    i2s_rx_fifo u_fifo (
        .clk        (clk),
        .rst_n      (rst_n),
        .in_frame   (src_frame),
        .push       (src_push),
        .out_frame  (out_frame),
        .out_valid  (out_valid),
        .out_ready  (out_ready),
        .drop       (drop)
    );

    i2s_rx_regs u_regs (
        .clk        (clk),
        .rst_n      (rst_n),
        .apb_req    (apb_req),
        .apb_rsp    (apb_rsp),
        .drop       (drop),
        .cfg        (cfg)
    );

endmodule

/* design/i2s_rx_regs.sv */
`timescale 1ns/1ps
`include "i2s_rx_cfg.svh"

module i2s_rx_regs (
    input  logic                 clk,
    input  logic                 rst_n,
    input  i2s_rx_pkg::apb_req_t apb_req,
    output i2s_rx_pkg::apb_rsp_t apb_rsp,
    input  logic                 drop,
    output i2s_rx_pkg::rx_cfg_t  cfg
);

    import i2s_rx_pkg::*;

    rx_cfg_t   cfg_q;
    logic      overrun_q;                       // Sticky FIFO overrun
    logic      access;
    logic      addr_hit;
    logic      wr_en;
    logic      ovr_clr;
    apb_data_t rdata;

    assign access  = apb_req.psel & apb_req.penable;
    assign wr_en   = access & apb_req.pwrite & addr_hit;
    assign ovr_clr = wr_en & (apb_req.paddr == `I2S_RX_ADDR_STATUS) & apb_req.pwdata[0];

    ////////////////////////////////////////////////////////////////////////////
    // Address decode and read data
    ////////////////////////////////////////////////////////////////////////////

    always_comb
    begin
        addr_hit = 1'b1;
        rdata    = '0;
        case (apb_req.paddr)
            `I2S_RX_ADDR_CTRL:       rdata = apb_data_t'({cfg_q.bist_sel, cfg_q.en});
            `I2S_RX_ADDR_BIST_START: rdata = apb_data_t'(cfg_q.bist_start);
            `I2S_RX_ADDR_BIST_INC:   rdata = apb_data_t'(cfg_q.bist_inc);
            `I2S_RX_ADDR_BIST_LIMIT: rdata = apb_data_t'(cfg_q.bist_limit);
            `I2S_RX_ADDR_STATUS:     rdata = apb_data_t'(overrun_q);
            default:                 addr_hit = 1'b0;   // Unmapped, reads zero
        endcase
    end

    // No wait states
    assign apb_rsp = '{prdata: rdata, pready: 1'b1, pslverr: access & ~addr_hit};

    ////////////////////////////////////////////////////////////////////////////
    // Configuration and status registers
    ////////////////////////////////////////////////////////////////////////////

    always_ff @(posedge clk or negedge rst_n)
    begin
        if (!rst_n)
            cfg_q <= '0;
        else if (wr_en)
        begin
            case (apb_req.paddr)
                `I2S_RX_ADDR_CTRL:
                begin
                    cfg_q.en       <= apb_req.pwdata[0];
                    cfg_q.bist_sel <= apb_req.pwdata[1];
                end
                `I2S_RX_ADDR_BIST_START: cfg_q.bist_start <= ramp_t'(apb_req.pwdata);
                `I2S_RX_ADDR_BIST_INC:   cfg_q.bist_inc   <= ramp_inc_t'(apb_req.pwdata);
                `I2S_RX_ADDR_BIST_LIMIT: cfg_q.bist_limit <= ramp_t'(apb_req.pwdata);
                default:                 cfg_q <= cfg_q;
            endcase
        end
    end

    always_ff @(posedge clk or negedge rst_n)
    begin
        if (!rst_n)
            overrun_q <= 1'b0;
        else if (drop)
            overrun_q <= 1'b1;                  // Set beats a clear in the same cycle
        else if (ovr_clr)
            overrun_q <= 1'b0;
    end

    assign cfg = cfg_q;

endmodule

/* design/i2s_rx_fifo.sv */
`timescale 1ns/1ps
`include "i2s_rx_cfg.svh"

module i2s_rx_fifo (
    input  logic               clk,
    input  logic               rst_n,
    input  i2s_rx_pkg::frame_t in_frame,
    input  logic               push,
    output i2s_rx_pkg::frame_t out_frame,
    output logic               out_valid,
    input  logic               out_ready,
    output logic               drop
);

    import i2s_rx_pkg::*;

    localparam int unsigned DEPTH = `I2S_RX_FIFO_DEPTH;
    localparam int unsigned PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;
    localparam int unsigned CNT_W = $clog2(DEPTH + 1);

    frame_t           mem [DEPTH];
    logic [PTR_W-1:0] wr_ptr;
    logic [PTR_W-1:0] rd_ptr;
    logic [CNT_W-1:0] count;
    logic             full;
    logic             wr_en;
    logic             rd_en;

    function automatic logic [PTR_W-1:0] ptr_inc(input logic [PTR_W-1:0] ptr);
        ptr_inc = (ptr == PTR_W'(DEPTH - 1)) ? '0 : ptr + 1'b1;
    endfunction

    assign full      = (count == CNT_W'(DEPTH));
    assign wr_en     = push & ~full;
    assign drop      = push & full;             // Incoming frame lost, contents kept
    assign out_valid = (count != '0);
    assign rd_en     = out_valid & out_ready;
    assign out_frame = mem[rd_ptr];             // Fall-through head

    always_ff @(posedge clk or negedge rst_n)
    begin
        if (!rst_n)
        begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end
        else
        begin
            if (wr_en)
                wr_ptr <= ptr_inc(wr_ptr);
            if (rd_en)
                rd_ptr <= ptr_inc(rd_ptr);
            case ({wr_en, rd_en})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
        end
    end

    always_ff @(posedge clk)
    begin
        if (wr_en)
            mem[wr_ptr] <= in_frame;
    end

endmodule

/* design/i2s_rx_bist_mux.sv */
`timescale 1ns/1ps
`include "i2s_rx_cfg.svh"

module i2s_rx_bist_mux (
    input  logic                clk,
    input  logic                rst_n,
    input  logic                sck_rise,
    input  i2s_rx_pkg::rx_cfg_t cfg,
    input  i2s_rx_pkg::frame_t  deser_frame,
    input  logic                deser_push,
    output i2s_rx_pkg::frame_t  frame,
    output logic                push
);

    import i2s_rx_pkg::*;

    localparam int unsigned DIV    = `I2S_RX_BIST_DIV;
    localparam int unsigned DIV_W  = $clog2(DIV);
    localparam int unsigned RAMP_W = $bits(ramp_t);

    logic [DIV_W-1:0] tick_cnt;
    logic             tick;                     // Ramp frame goes out this cycle
    ramp_t            ramp_q;                   // Value of the next ramp frame
    logic [RAMP_W:0]  ramp_sum;                 // Extra bit keeps the carry
    frame_t           ramp_frame;

    assign tick     = cfg.bist_sel & sck_rise & (tick_cnt == DIV_W'(DIV - 1));
    assign ramp_sum = {1'b0, ramp_q} + (RAMP_W + 1)'(cfg.bist_inc);

    always_ff @(posedge clk or negedge rst_n)
    begin
        if (!rst_n)
        begin
            tick_cnt <= '0;
            ramp_q   <= '0;
        end
        else if (!cfg.bist_sel)
        begin
            tick_cnt <= '0;
            ramp_q   <= cfg.bist_start;         // Restart whenever deselected
        end
        else if (sck_rise)
        begin
            tick_cnt <= tick ? '0 : tick_cnt + 1'b1;
            if (tick)
            begin
                if (ramp_sum > {1'b0, cfg.bist_limit})
                    ramp_q <= cfg.bist_start;   // Wrap past the limit
                else
                    ramp_q <= ramp_sum[RAMP_W-1:0];
            end
        end
    end

    assign ramp_frame = '{left: sample_t'(ramp_q), right: sample_t'(ramp_q)};

    // Source select
    assign frame = cfg.bist_sel ? ramp_frame : deser_frame;
    assign push  = cfg.bist_sel ? tick : deser_push;

endmodule

/* design/i2s_rx_deser.sv */
`timescale 1ns/1ps

module i2s_rx_deser (
    input  logic                clk,
    input  logic                rst_n,
    input  logic                sck_rise,
    input  logic                ws,
    input  logic                sd,
    input  i2s_rx_pkg::rx_cfg_t cfg,
    output i2s_rx_pkg::frame_t  frame,
    output logic                frame_push
);

    import i2s_rx_pkg::*;

    localparam int unsigned SAMPLE_W = $bits(sample_t);
    localparam int unsigned CNT_W    = $clog2(SAMPLE_W + 1);

    deser_state_e     state;
    logic             ws_last;                  // ws seen on the previous sck rise
    logic [CNT_W-1:0] bit_cnt;
    logic             left_ok;                  // Left word of this pair complete
    logic             right_ok;                 // Right word complete after a left one
    sample_t          shift_q;
    sample_t          shift_nxt;
    sample_t          left_q;
    sample_t          right_q;
    logic             ws_chg;
    logic             bit_take;
    logic             word_done;

    assign ws_chg    = ws ^ ws_last;
    assign shift_nxt = {shift_q[SAMPLE_W-2:0], sd};

    // First SAMPLE_W bits after the skipped one, extra bits dropped
    assign bit_take  = cfg.en & sck_rise & ~ws_chg &
                       ((state == DS_SKIP) |
                        ((state == DS_SHIFT) & (bit_cnt < CNT_W'(SAMPLE_W))));
    assign word_done = bit_take & (bit_cnt == CNT_W'(SAMPLE_W - 1));

    ////////////////////////////////////////////////////////////////////////////
    // Control FSM
    ////////////////////////////////////////////////////////////////////////////

    always_ff @(posedge clk or negedge rst_n)
    begin
        if (!rst_n)
        begin
            state      <= DS_IDLE;
            ws_last    <= 1'b0;
            bit_cnt    <= '0;
            left_ok    <= 1'b0;
            right_ok   <= 1'b0;
            frame_push <= 1'b0;
        end
        else
        begin
            frame_push <= 1'b0;
            if (sck_rise)
                ws_last <= ws;

            if (!cfg.en)
            begin
                state    <= DS_IDLE;
                left_ok  <= 1'b0;
                right_ok <= 1'b0;
            end
            else if (sck_rise && ws_chg)
            begin
                state   <= DS_SKIP;             // This rise carries the old LSB
                bit_cnt <= '0;
                if (!ws && right_ok)
                begin
                    frame_push <= 1'b1;         // ws fell, right word ended
                    left_ok    <= 1'b0;
                    right_ok   <= 1'b0;
                end
            end
            else if (bit_take)
            begin
                state   <= DS_SHIFT;
                bit_cnt <= bit_cnt + 1'b1;
                if (word_done)
                begin
                    if (!ws)
                    begin
                        left_ok  <= 1'b1;
                        right_ok <= 1'b0;
                    end
                    else if (left_ok)
                        right_ok <= 1'b1;
                end
            end
        end
    end

    ////////////////////////////////////////////////////////////////////////////
    // Sample datapath
    ////////////////////////////////////////////////////////////////////////////

    always_ff @(posedge clk)
    begin
        if (bit_take)
            shift_q <= shift_nxt;               // MSB first
        if (word_done && !ws)
            left_q <= shift_nxt;
        if (word_done && ws)
            right_q <= shift_nxt;
    end

    assign frame = '{left: left_q, right: right_q};

endmodule

/* design/i2s_rx_sync.sv */
`timescale 1ns/1ps

module i2s_rx_sync (
    input  logic clk,
    input  logic rst_n,
    input  logic sck_pin,
    input  logic ws_pin,
    input  logic sd_pin,
    output logic sck_rise,
    output logic ws,
    output logic sd
);

    // Stages 0 and 1 synchronize, stage 2 lines up with the edge pulse
    logic [2:0] sck_q;
    logic [2:0] ws_q;
    logic [2:0] sd_q;
    logic       rise_q;

    always_ff @(posedge clk or negedge rst_n)
    begin
        if (!rst_n)
        begin
            sck_q  <= '0;
            ws_q   <= '0;
            sd_q   <= '0;
            rise_q <= 1'b0;
        end
        else
        begin
            sck_q  <= {sck_q[1:0], sck_pin};
            ws_q   <= {ws_q[1:0], ws_pin};
            sd_q   <= {sd_q[1:0], sd_pin};
            rise_q <= sck_q[1] & ~sck_q[2];     // Registered edge, third cycle
        end
    end

    assign sck_rise = rise_q;
    assign ws       = ws_q[2];                  // Same delay as sck_rise
    assign sd       = sd_q[2];

endmodule

/* design/i2s_rx_pkg.sv */
package i2s_rx_pkg;

    typedef logic [15:0] sample_t;              // One audio sample
    typedef logic [11:0] ramp_t;                // Test ramp value
    typedef logic [7:0]  ramp_inc_t;            // Test ramp step
    typedef logic [7:0]  apb_addr_t;
    typedef logic [31:0] apb_data_t;

    // Stereo pair, left sample in the upper half
    typedef struct packed {
        sample_t left;
        sample_t right;
    } frame_t;

    typedef struct packed {
        apb_addr_t paddr;
        logic      psel;
        logic      penable;
        logic      pwrite;
        apb_data_t pwdata;
    } apb_req_t;

    typedef struct packed {
        apb_data_t prdata;
        logic      pready;
        logic      pslverr;
    } apb_rsp_t;

    typedef struct packed {
        logic      en;                          // Deserializer enable
        logic      bist_sel;                    // Ramp replaces the deserializer
        ramp_t     bist_start;
        ramp_inc_t bist_inc;
        ramp_t     bist_limit;
    } rx_cfg_t;

    typedef enum logic [1:0] {
        DS_IDLE,                                // Waiting for a ws edge
        DS_SKIP,                                // Edge seen, next bit is the MSB
        DS_SHIFT                                // Collecting sample bits
    } deser_state_e;

endpackage

/* design/i2s_rx_cfg.svh */
`ifndef I2S_RX_CFG_SVH
`define I2S_RX_CFG_SVH

////////////////////////////////////////////////////////////////////////////
// Sizing
////////////////////////////////////////////////////////////////////////////

`define I2S_RX_FIFO_DEPTH       8               // Frames held in the output FIFO
`define I2S_RX_BIST_DIV         32              // sck rises per ramp frame, one stereo frame

////////////////////////////////////////////////////////////////////////////
// APB register byte offsets
////////////////////////////////////////////////////////////////////////////

`define I2S_RX_ADDR_CTRL        8'h00           // en, bist_sel
`define I2S_RX_ADDR_BIST_START  8'h04
`define I2S_RX_ADDR_BIST_INC    8'h08
`define I2S_RX_ADDR_BIST_LIMIT  8'h0C
`define I2S_RX_ADDR_STATUS      8'h10           // Sticky overrun, write 1 to clear

`endif
